// File: design/align_pkg.sv
`default_nettype none

package align_pkg;

    localparam int SCORE_W = 12;
    localparam int IDX_W = 8;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [IDX_W-1:0] idx_t;
    // A C G T, then N
    typedef logic [2:0] nt_t;

    localparam nt_t NT_N = 3'd4;
    localparam score_t NEG_INF = -12'sd1024;
    localparam score_t SCORE_MAX = 12'sd2047;

    typedef struct packed {
        score_t match;
        score_t mismatch;
        score_t n_score;
        score_t gap_open;
        score_t gap_extend;
    } score_params_t;

    // one column travelling down the array
    typedef struct packed {
        logic   valid;
        nt_t    nt;
        idx_t   ref_idx;
        score_t h;
        score_t f;
    } pe_link_t;

    typedef struct packed {
        logic   valid;
        score_t score;
        idx_t   ref_idx;
        idx_t   query_idx;
    } ad_entry_t;

    typedef struct packed {
        score_t max_score;
        idx_t   ref_end;
        idx_t   query_end;
        logic   xdropped;
    } align_result_t;

    // floor at NEG_INF, clamp on the top side as well
    function automatic score_t sat_add(score_t a, score_t b);
        logic signed [SCORE_W:0] sum;
        sum = a + b;
        if (sum < NEG_INF) begin
            return NEG_INF;
        end
        if (sum > SCORE_MAX) begin
            return SCORE_MAX;
        end
        return sum[SCORE_W-1:0];
    endfunction

    function automatic score_t smax(score_t a, score_t b);
        return (a > b) ? a : b;
    endfunction

    // H(k,0) of the left and top borders, H(0,0) is 0
    function automatic score_t boundary_h(score_params_t p, int unsigned k);
        score_t h;
        h = '0;
        if (k > 0) begin
            h = p.gap_open;
            for (int unsigned n = 1; n < k; n++) begin
                h = sat_add(h, p.gap_extend);
            end
        end
        return h;
    endfunction

endpackage

`default_nettype wire

// File: design/pe_cell.sv
`timescale 1ns/1ps
`default_nettype none

module pe_cell #(
    parameter int PE_IDX = 0
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          clear,
    input  wire                          load,
    input  wire align_pkg::nt_t          query_nt,
    input  wire align_pkg::score_params_t params,
    input  wire align_pkg::pe_link_t     link_in,
    output align_pkg::pe_link_t          link_out,
    output align_pkg::ad_entry_t         entry
);

    align_pkg::nt_t    q_nt;
    logic              active;
    // H(i,j-1), E(i,j-1) and H(i-1,j-1) of this row
    align_pkg::score_t h_left;
    align_pkg::score_t e_left;
    align_pkg::score_t h_diag;

    align_pkg::score_t sub;
    align_pkg::score_t e_new;
    align_pkg::score_t f_new;
    align_pkg::score_t h_new;

    always_comb begin
        if (q_nt == align_pkg::NT_N || link_in.nt == align_pkg::NT_N) begin
            sub = params.n_score;
        end else if (q_nt == link_in.nt) begin
            sub = params.match;
        end else begin
            sub = params.mismatch;
        end
        // horizontal gap from the left neighbour cell
        e_new = align_pkg::smax(align_pkg::sat_add(h_left, params.gap_open),
                                align_pkg::sat_add(e_left, params.gap_extend));
        // vertical gap from the row above
        f_new = align_pkg::smax(align_pkg::sat_add(link_in.h, params.gap_open),
                                align_pkg::sat_add(link_in.f, params.gap_extend));
        h_new = align_pkg::smax(align_pkg::sat_add(h_diag, sub),
                                align_pkg::smax(e_new, f_new));
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            active <= 1'b0;
            link_out.valid <= 1'b0;
        end else begin
            if (load) begin
                active <= 1'b1;
            end
            link_out.valid <= link_in.valid;
        end

        if (load) begin
            q_nt <= query_nt;
            // left border of row PE_IDX+1
            h_left <= align_pkg::boundary_h(params, PE_IDX + 1);
            e_left <= align_pkg::NEG_INF;
            h_diag <= align_pkg::boundary_h(params, PE_IDX);
        end else if (link_in.valid) begin
            h_left <= h_new;
            e_left <= e_new;
            h_diag <= link_in.h;
            link_out.nt <= link_in.nt;
            link_out.ref_idx <= link_in.ref_idx;
            link_out.h <= h_new;
            link_out.f <= f_new;
        end
    end

    // rows without a query character never report
    assign entry = '{
        valid:     active && link_out.valid,
        score:     link_out.h,
        ref_idx:   link_out.ref_idx,
        query_idx: align_pkg::idx_t'(PE_IDX + 1)
    };

endmodule

`default_nettype wire

// File: design/pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array #(
    parameter int NUM_PE = 8
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          clear,
    input  wire                          query_load,
    input  wire align_pkg::nt_t          query_nt,
    input  wire align_pkg::score_params_t params,
    input  wire align_pkg::pe_link_t     ref_in,
    output align_pkg::ad_entry_t         ad_entries [NUM_PE]
);

    align_pkg::score_params_t params_q;
    align_pkg::score_t        top_h;
    align_pkg::pe_link_t      top_link;
    align_pkg::pe_link_t      links [NUM_PE];
    // last loaded PE, all zero before the first query character
    logic [NUM_PE-1:0]        load_sel;
    logic [NUM_PE-1:0]        load_next;

    assign load_next = (load_sel == '0) ? NUM_PE'(1) : (load_sel << 1);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            load_sel <= '0;
        end else if (query_load) begin
            load_sel <= load_next;
        end
    end

    // scores are taken with start, the top row H(0,j) runs along the stream
    always_ff @(posedge clk) begin
        if (clear) begin
            params_q <= params;
            top_h <= params.gap_open;
        end else if (ref_in.valid) begin
            top_h <= align_pkg::sat_add(top_h, params_q.gap_extend);
        end
    end

    always_comb begin
        top_link = ref_in;
        top_link.h = top_h;
        top_link.f = align_pkg::NEG_INF;
    end

    genvar i;
    generate
        for (i = 0; i < NUM_PE; i++) begin : g_pe
            align_pkg::pe_link_t link_in;

            if (i == 0) begin : g_first
                assign link_in = top_link;
            end else begin : g_next
                assign link_in = links[i-1];
            end

            pe_cell #(
                .PE_IDX(i)
            ) u_cell (
                .clk(clk),
                .rst(rst),
                .clear(clear),
                .load(query_load && load_next[i]),
                .query_nt(query_nt),
                .params(params_q),
                .link_in(link_in),
                .link_out(links[i]),
                .entry(ad_entries[i])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module max_tree #(
    parameter int NUM_PE = 8
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire align_pkg::ad_entry_t entries [NUM_PE],
    output align_pkg::ad_entry_t  best
);

    localparam int LEVELS = $clog2(NUM_PE);
    localparam int LEAVES = 1 << LEVELS;

    // valid beats invalid, then higher score, then lower query index
    function automatic align_pkg::ad_entry_t pick(align_pkg::ad_entry_t a,
                                                  align_pkg::ad_entry_t b);
        if (!a.valid) begin
            return b;
        end
        if (!b.valid) begin
            return a;
        end
        if (a.score != b.score) begin
            return (a.score > b.score) ? a : b;
        end
        return (a.query_idx <= b.query_idx) ? a : b;
    endfunction

    genvar l, k;
    generate
        for (l = 0; l <= LEVELS; l++) begin : g_lvl
            align_pkg::ad_entry_t v [LEAVES >> l];

            for (k = 0; k < (LEAVES >> l); k++) begin : g_node
                if (l == 0 && k < NUM_PE) begin : g_leaf
                    assign v[k] = entries[k];
                end else if (l == 0) begin : g_pad
                    assign v[k] = '0;
                end else begin : g_cmp
                    assign v[k] = pick(g_lvl[l-1].v[2*k], g_lvl[l-1].v[2*k+1]);
                end
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            best <= '0;
        end else begin
            best <= g_lvl[LEVELS].v[0];
        end
    end

endmodule

`default_nettype wire

// File: design/align_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module align_ctrl #(
    parameter int NUM_PE = 8,
    parameter int MAX_REF_LEN = 64
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire align_pkg::idx_t       ref_len,
    input  wire align_pkg::idx_t       query_len,
    input  wire align_pkg::score_t     xdrop,
    output logic                       query_rd_en,
    output align_pkg::idx_t            query_addr,
    output logic                       query_load,
    output logic                       ref_rd_en,
    output align_pkg::idx_t            ref_addr,
    output logic                       ref_valid,
    output logic                       array_clear,
    input  wire align_pkg::ad_entry_t  ad_best,
    output logic                       busy,
    output logic                       done,
    output align_pkg::align_result_t   result
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD_QUERY,
        STREAM_REF,
        DRAIN,
        DONE
    } state_t;

    state_t                            state;
    align_pkg::idx_t                   q_len;
    align_pkg::idx_t                   r_len;
    align_pkg::idx_t                   q_eff;
    align_pkg::idx_t                   r_eff;
    align_pkg::score_t                 xdrop_q;
    logic [align_pkg::IDX_W:0]         ad_cnt;
    logic [align_pkg::IDX_W:0]         ad_last;
    logic signed [align_pkg::SCORE_W:0] ad_reach;
    logic                              accept;
    logic                              ad_take;
    logic                              x_hit;
    logic                              ad_better;

    assign busy = (state != IDLE) && (state != DONE);
    assign done = (state == DONE);
    assign accept = start && !busy;
    assign array_clear = accept;

    // lengths beyond the array or the reference limit are cut
    assign q_eff = (query_len > align_pkg::idx_t'(NUM_PE)) ?
                   align_pkg::idx_t'(NUM_PE) : query_len;
    assign r_eff = (ref_len > align_pkg::idx_t'(MAX_REF_LEN)) ?
                   align_pkg::idx_t'(MAX_REF_LEN) : ref_len;

    // anti-diagonals only count once the reference is on its way
    assign ad_take = ad_best.valid && (state == STREAM_REF || state == DRAIN);
    assign ad_reach = ad_best.score + xdrop_q;
    assign x_hit = ad_reach < result.max_score;
    assign ad_better = ad_best.score >= result.max_score;

    always_ff @(posedge clk) begin
        if (accept) begin
            q_len <= q_eff;
            r_len <= r_eff;
            xdrop_q <= xdrop;
            // anti-diagonals 2 .. q+r, counted from zero
            ad_last <= {1'b0, q_eff} + {1'b0, r_eff} - 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            query_rd_en <= 1'b0;
            query_addr <= '0;
            query_load <= 1'b0;
            ref_rd_en <= 1'b0;
            ref_addr <= '0;
            ref_valid <= 1'b0;
            ad_cnt <= '0;
            result <= '0;
        end else begin
            // memories answer one cycle after the read
            query_load <= query_rd_en;
            ref_valid <= ref_rd_en;

            case (state)
                IDLE, DONE: begin
                    state <= IDLE;
                    if (accept) begin
                        state <= LOAD_QUERY;
                        query_rd_en <= 1'b1;
                        query_addr <= '0;
                        ad_cnt <= '0;
                        // best so far is H(0,0) = 0
                        result <= '0;
                    end
                end
                LOAD_QUERY: begin
                    query_addr <= query_addr + 1'b1;
                    if (query_addr == q_len - 1'b1) begin
                        query_rd_en <= 1'b0;
                        ref_rd_en <= 1'b1;
                        ref_addr <= '0;
                        state <= STREAM_REF;
                    end
                end
                STREAM_REF: begin
                    // address runs one ahead, so it equals the 1-based column on data
                    ref_addr <= ref_addr + 1'b1;
                    if (ref_addr == r_len - 1'b1) begin
                        ref_rd_en <= 1'b0;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    state <= DRAIN;
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (ad_take) begin
                ad_cnt <= ad_cnt + 1'b1;
                if (x_hit) begin
                    // stop the stream, the rest in flight is dropped
                    result.xdropped <= 1'b1;
                    ref_rd_en <= 1'b0;
                    state <= DONE;
                end else begin
                    if (ad_better) begin
                        result.max_score <= ad_best.score;
                        result.ref_end <= ad_best.ref_idx;
                        result.query_end <= ad_best.query_idx;
                    end
                    if (ad_cnt == ad_last) begin
                        state <= DONE;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/xdrop_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module xdrop_aligner #(
    parameter int NUM_PE = 8,
    parameter int MAX_REF_LEN = 64
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           start,
    input  wire align_pkg::idx_t          ref_len,
    input  wire align_pkg::idx_t          query_len,
    input  wire align_pkg::score_params_t params,
    input  wire align_pkg::score_t        xdrop,
    output logic                          query_rd_en,
    output align_pkg::idx_t               query_addr,
    input  wire align_pkg::nt_t           query_data,
    output logic                          ref_rd_en,
    output align_pkg::idx_t               ref_addr,
    input  wire align_pkg::nt_t           ref_data,
    output logic                          busy,
    output logic                          done,
    output align_pkg::align_result_t      result
);

    logic                 query_load;
    logic                 ref_valid;
    logic                 array_clear;
    align_pkg::pe_link_t  ref_in;
    align_pkg::ad_entry_t ad_entries [NUM_PE];
    align_pkg::ad_entry_t ad_best;

    // column j enters with its 1-based index, scores come from the array
    assign ref_in = '{
        valid:   ref_valid,
        nt:      ref_data,
        ref_idx: ref_addr,
        h:       align_pkg::NEG_INF,
        f:       align_pkg::NEG_INF
    };

    align_ctrl #(
        .NUM_PE(NUM_PE),
        .MAX_REF_LEN(MAX_REF_LEN)
    ) u_ctrl (
        .clk(clk),
        .rst(rst),
        .start(start),
        .ref_len(ref_len),
        .query_len(query_len),
        .xdrop(xdrop),
        .query_rd_en(query_rd_en),
        .query_addr(query_addr),
        .query_load(query_load),
        .ref_rd_en(ref_rd_en),
        .ref_addr(ref_addr),
        .ref_valid(ref_valid),
        .array_clear(array_clear),
        .ad_best(ad_best),
        .busy(busy),
        .done(done),
        .result(result)
    );

    pe_array #(
        .NUM_PE(NUM_PE)
    ) u_array (
        .clk(clk),
        .rst(rst),
        .clear(array_clear),
        .query_load(query_load),
        .query_nt(query_data),
        .params(params),
        .ref_in(ref_in),
        .ad_entries(ad_entries)
    );

    max_tree #(
        .NUM_PE(NUM_PE)
    ) u_tree (
        .clk(clk),
        .rst(rst),
        .entries(ad_entries),
        .best(ad_best)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_NS = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: verification/tb_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aligner;

    localparam int NUM_PE = 8;
    localparam int MAX_REF_LEN = 64;
    localparam int NEG = -1024;
    localparam int DONE_LIMIT = 2000;
    localparam align_pkg::score_params_t BASE_PARAMS = '{
        match:      12'sd2,
        mismatch:  -12'sd3,
        n_score:   -12'sd1,
        gap_open:  -12'sd5,
        gap_extend: -12'sd2
    };

    logic                     clk;
    logic                     rst;
    logic                     start;
    align_pkg::idx_t          ref_len;
    align_pkg::idx_t          query_len;
    align_pkg::score_params_t params;
    align_pkg::score_t        xdrop;
    logic                     query_rd_en;
    align_pkg::idx_t          query_addr;
    align_pkg::nt_t           query_data = '0;
    logic                     ref_rd_en;
    align_pkg::idx_t          ref_addr;
    align_pkg::nt_t           ref_data = '0;
    logic                     busy;
    logic                     done;
    align_pkg::align_result_t result;

    align_pkg::nt_t           q_mem [256];
    align_pkg::nt_t           r_mem [256];
    align_pkg::align_result_t exp_res = '0;
    logic [31:0]              rng = 32'h189f;
    int                       errors = 0;
    int                       checks = 0;
    int                       tests = 0;
    bit                       timed_out = 1'b0;
    logic                     done_last = 1'b0;

    tb_clock #(.HALF_NS(20)) u_clock (.clk(clk));

    xdrop_aligner #(
        .NUM_PE(NUM_PE),
        .MAX_REF_LEN(MAX_REF_LEN)
    ) uut (
        .clk(clk), .rst(rst), .start(start), .ref_len(ref_len), .query_len(query_len),
        .params(params), .xdrop(xdrop), .query_rd_en(query_rd_en),
        .query_addr(query_addr), .query_data(query_data), .ref_rd_en(ref_rd_en),
        .ref_addr(ref_addr), .ref_data(ref_data), .busy(busy), .done(done),
        .result(result)
    );

    // both memories answer one cycle after the read enable
    always @(posedge clk) begin
        if (query_rd_en) begin
            query_data <= q_mem[query_addr];
        end
        if (ref_rd_en) begin
            ref_data <= r_mem[ref_addr];
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(int n);
        rng = xorshift(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic int floor_neg(int v);
        return (v < NEG) ? NEG : v;
    endfunction

    function automatic int max_int(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // full affine matrix, then anti-diagonal scan with the X-drop rule
    function automatic align_pkg::align_result_t expected_result(
        align_pkg::score_params_t p, int ql, int rl, int xd);
        int h [0:NUM_PE][0:MAX_REF_LEN];
        int e [0:NUM_PE][0:MAX_REF_LEN];
        int f [0:NUM_PE][0:MAX_REF_LEN];
        int i, j, d, s, best, bi, bj, gmax, gi, gj;
        align_pkg::align_result_t r;
        r = '0;
        h[0][0] = 0;
        for (i = 1; i <= ql; i++) begin
            h[i][0] = (i == 1) ? int'(p.gap_open) : floor_neg(h[i-1][0] + p.gap_extend);
            e[i][0] = NEG;
        end
        for (j = 1; j <= rl; j++) begin
            h[0][j] = (j == 1) ? int'(p.gap_open) : floor_neg(h[0][j-1] + p.gap_extend);
            f[0][j] = NEG;
        end
        for (i = 1; i <= ql; i++) begin
            for (j = 1; j <= rl; j++) begin
                if (q_mem[i-1] == 3'd4 || r_mem[j-1] == 3'd4) begin
                    s = p.n_score;
                end else if (q_mem[i-1] == r_mem[j-1]) begin
                    s = p.match;
                end else begin
                    s = p.mismatch;
                end
                e[i][j] = max_int(floor_neg(h[i][j-1] + p.gap_open),
                                  floor_neg(e[i][j-1] + p.gap_extend));
                f[i][j] = max_int(floor_neg(h[i-1][j] + p.gap_open),
                                  floor_neg(f[i-1][j] + p.gap_extend));
                h[i][j] = max_int(floor_neg(h[i-1][j-1] + s), max_int(e[i][j], f[i][j]));
            end
        end
        gmax = 0;
        gi = 0;
        gj = 0;
        for (d = 2; d <= ql + rl; d++) begin
            best = NEG - 1;
            bi = 0;
            bj = 0;
            // strict compare keeps the smallest query index on ties
            for (i = 1; i <= ql; i++) begin
                j = d - i;
                if (j >= 1 && j <= rl && h[i][j] > best) begin
                    best = h[i][j];
                    bi = i;
                    bj = j;
                end
            end
            if (best + xd < gmax) begin
                r.xdropped = 1'b1;
                break;
            end
            if (best >= gmax) begin
                gmax = best;
                gi = bi;
                gj = bj;
            end
        end
        r.max_score = align_pkg::score_t'(gmax);
        r.ref_end = align_pkg::idx_t'(gj);
        r.query_end = align_pkg::idx_t'(gi);
        return r;
    endfunction

    function automatic string result_text(align_pkg::align_result_t r);
        return $sformatf("%0d at (%0d,%0d) xdrop %0b",
                         r.max_score, r.query_end, r.ref_end, r.xdropped);
    endfunction

    task automatic check_result(input align_pkg::align_result_t got,
                                input align_pkg::align_result_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %s, expected %s",
                     $time, what, result_text(got), result_text(exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // result, busy and the done pulse are looked at in mid-cycle
    always @(negedge clk) begin
        if (done_last) begin
            check_bit(done, 1'b0, "done one cycle after its pulse");
        end
        if (done) begin
            check_result(result, exp_res, "result at done");
            check_bit(busy, 1'b0, "busy at done");
        end
        done_last = done;
    end

    task automatic start_run(input int ql, input int rl, input align_pkg::score_params_t p,
                             input align_pkg::score_t xd);
        @(posedge clk);
        start <= 1'b1;
        query_len <= align_pkg::idx_t'(ql);
        ref_len <= align_pkg::idx_t'(rl);
        params <= p;
        xdrop <= xd;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
            seen = done;
        end
    endtask

    task automatic finish_case(input string name, input int err0, input bit seen);
        @(posedge clk);
        tests++;
        if (!seen) begin
            timed_out = 1'b1;
            $display("%s: done never came within %0d cycles", name, DONE_LIMIT);
        end else if (errors == err0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - err0);
        end
    endtask

    task automatic run_case(input string name, input int ql, input int rl,
                            input align_pkg::score_params_t p, input align_pkg::score_t xd,
                            input align_pkg::align_result_t exp);
        int err0;
        bit seen;
        if (timed_out) begin
            return;
        end
        err0 = errors;
        exp_res = exp;
        start_run(ql, rl, p, xd);
        wait_done(seen);
        finish_case(name, err0, seen);
    endtask

    task automatic draw_params(output align_pkg::score_params_t p);
        p.match = align_pkg::score_t'(1 + rand_below(6));
        p.mismatch = align_pkg::score_t'(-1 - rand_below(6));
        p.n_score = align_pkg::score_t'(-rand_below(3));
        p.gap_open = align_pkg::score_t'(-2 - rand_below(8));
        p.gap_extend = align_pkg::score_t'(-1 - rand_below(4));
    endtask

    task automatic identical_case();
        align_pkg::align_result_t exp;
        for (int k = 0; k < NUM_PE; k++) begin
            q_mem[k] = align_pkg::nt_t'(rand_below(4));
            r_mem[k] = q_mem[k];
        end
        exp = '0;
        exp.max_score = align_pkg::score_t'(NUM_PE * int'(BASE_PARAMS.match));
        exp.ref_end = align_pkg::idx_t'(NUM_PE);
        exp.query_end = align_pkg::idx_t'(NUM_PE);
        run_case("identical", NUM_PE, NUM_PE, BASE_PARAMS, 12'sd100, exp);
    endtask

    // A C G prefix, then a tail of T that matches nothing
    task automatic xdrop_tail_case();
        align_pkg::align_result_t exp;
        for (int k = 0; k < 40; k++) begin
            r_mem[k] = 3'd3;
        end
        for (int k = 0; k < NUM_PE; k++) begin
            q_mem[k] = align_pkg::nt_t'(rand_below(3));
            r_mem[k] = q_mem[k];
        end
        exp = '0;
        exp.max_score = align_pkg::score_t'(NUM_PE * int'(BASE_PARAMS.match));
        exp.ref_end = align_pkg::idx_t'(NUM_PE);
        exp.query_end = align_pkg::idx_t'(NUM_PE);
        exp.xdropped = 1'b1;
        run_case("xdrop tail", NUM_PE, 40, BASE_PARAMS, 12'sd6, exp);
    endtask

    task automatic n_code_case();
        align_pkg::nt_t q_seq [5];
        align_pkg::nt_t r_seq [12];
        q_seq = '{3'd0, 3'd4, 3'd2, 3'd3, 3'd1};
        r_seq = '{3'd0, 3'd4, 3'd4, 3'd2, 3'd3, 3'd1, 3'd0, 3'd2, 3'd4, 3'd1, 3'd3, 3'd3};
        for (int k = 0; k < 5; k++) begin
            q_mem[k] = q_seq[k];
        end
        for (int k = 0; k < 12; k++) begin
            r_mem[k] = r_seq[k];
        end
        run_case("n codes", 5, 12, BASE_PARAMS, 12'sd10,
                 expected_result(BASE_PARAMS, 5, 12, 10));
    endtask

    task automatic random_case(input int n);
        int ql;
        int rl;
        align_pkg::score_params_t p;
        align_pkg::score_t xd;
        ql = 1 + rand_below(NUM_PE);
        rl = 1 + rand_below(40);
        for (int k = 0; k < ql; k++) begin
            q_mem[k] = align_pkg::nt_t'(rand_below(5));
        end
        for (int k = 0; k < rl; k++) begin
            r_mem[k] = align_pkg::nt_t'(rand_below(5));
        end
        draw_params(p);
        xd = align_pkg::score_t'(rand_below(20));
        run_case($sformatf("random %0d", n), ql, rl, p, xd, expected_result(p, ql, rl, xd));
    endtask

    // second start arrives mid-run with other lengths and scores
    task automatic busy_start_case();
        align_pkg::score_params_t other;
        int err0;
        bit seen;
        if (timed_out) begin
            return;
        end
        for (int k = 0; k < 30; k++) begin
            q_mem[k % NUM_PE] = align_pkg::nt_t'(rand_below(4));
            r_mem[k] = align_pkg::nt_t'(rand_below(4));
        end
        draw_params(other);
        err0 = errors;
        exp_res = expected_result(BASE_PARAMS, NUM_PE, 30, 12);
        start_run(NUM_PE, 30, BASE_PARAMS, 12'sd12);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit(busy, 1'b1, "busy during run");
        start_run(3, 5, other, 12'sd0);
        wait_done(seen);
        if (seen) begin
            repeat (3) @(negedge clk);
            check_bit(busy, 1'b0, "busy after done");
            check_result(result, exp_res, "result held after done");
        end
        finish_case("start while busy", err0, seen);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        ref_len = '0;
        query_len = '0;
        params = '0;
        xdrop = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_bit(query_rd_en, 1'b0, "query_rd_en after reset");
        check_bit(ref_rd_en, 1'b0, "ref_rd_en after reset");
        check_result(result, '0, "result after reset");
        tests++;
        $display("reset: %s", (errors == 0) ? "passed" : "mismatch");
        identical_case();
        xdrop_tail_case();
        n_code_case();
        for (int n = 0; n < 50; n++) begin
            random_case(n);
        end
        busy_start_case();
        $display("tests %0d, checks %0d, errors %0d, timeout %0b",
                 tests, checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/align_pkg.sv
design/pe_cell.sv
design/pe_array.sv
design/max_tree.sv
design/align_ctrl.sv
design/xdrop_aligner.sv
verification/tb_clock.sv
verification/tb_aligner.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_aligner
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_TEXT := Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
